/* dv/soc_fabric_chk.sv */
`timescale 1ns/1ps

module soc_fabric_chk import bus_pkg::*, soc_map_pkg::*; (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              sys_rst_ni,
  input logic              rtc_i,
  input logic              req_i,
  input logic              we_i,
  input logic [ADDR_W-1:0] addr_i,
  input logic [BE_W-1:0]   be_i,
  input logic [DATA_W-1:0] wdata_i,
  input logic              dbg_req_i,
  input logic              dbg_en_i,
  input logic              rvalid_i,
  input logic [DATA_W-1:0] rdata_i,
  input logic              err_i,
  input logic              timer_irq_i,
  input logic              ipi_i,
  input logic              dbg_out_i
);

  logic [DATA_W-1:0] shadow [SRAM_WORDS];
  logic [DATA_W-1:0] mtimecmp_m;
  logic              msip_m;
  logic              rtc_s;
  logic [DATA_W-1:0] rtc_cnt;
  logic [DATA_W-1:0] rtc_cnt_d1;
  logic [DATA_W-1:0] mtime_m;
  logic              exp_valid_q;
  logic              exp_err_q;
  logic [DATA_W-1:0] exp_rdata_q;
  logic              exp_irq;
  logic              exp_dbg;
  int unsigned       powered_cycles;
  int                fail_cnt = 0;

  function automatic logic [OFFSET_W-1:0] word_ofs(logic [ADDR_W-1:0] addr);
    return {addr[OFFSET_W-1:WORD_OFS_W], {WORD_OFS_W{1'b0}}};
  endfunction

  // Error rules of the address map
  function automatic logic addr_bad(logic [ADDR_W-1:0] addr);
    logic [OFFSET_W-1:0] ofs;
    logic [OFFSET_W-1:0] wofs;
    ofs = addr[OFFSET_W-1:0];
    wofs = word_ofs(addr);
    case (addr[ADDR_W-1:OFFSET_W])
      REGION_ROM:   return !(ofs >= ROM_BASE_OFS && ofs < ROM_BASE_OFS + ROM_BYTES);
      REGION_DRAM:  return ofs >= SRAM_BYTES;
      REGION_CLINT: return !(wofs == CLINT_MSIP_OFS || wofs == CLINT_MTIMECMP_OFS ||
                             wofs == CLINT_MTIME_OFS);
      default:      return 1'b1;
    endcase
  endfunction

  function automatic logic [DATA_W-1:0] read_model(logic [ADDR_W-1:0] addr);
    logic [OFFSET_W-1:0] wofs;
    wofs = word_ofs(addr);
    case (addr[ADDR_W-1:OFFSET_W])
      REGION_ROM:  return boot_rom_image[ROM_AW'((wofs - ROM_BASE_OFS) >> WORD_OFS_W)];
      REGION_DRAM: return shadow[addr[WORD_OFS_W +: SRAM_AW]];
      default: begin
        if (wofs == CLINT_MSIP_OFS) return {{(DATA_W-1){1'b0}}, msip_m};
        if (wofs == CLINT_MTIMECMP_OFS) return mtimecmp_m;
        return mtime_m;
      end
    endcase
  endfunction

  // ----------------------------------------
  // Reference models
  // ----------------------------------------

  // Shadow survives any reset
  always_ff @(posedge clk_i) begin
    if (req_i && we_i && !addr_bad(addr_i) && addr_i[ADDR_W-1:OFFSET_W] == REGION_DRAM) begin
      for (int i = 0; i < BE_W; i++) begin
        if (be_i[i]) begin
          shadow[addr_i[WORD_OFS_W +: SRAM_AW]][i*8 +: 8] <= wdata_i[i*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge sys_rst_ni) begin
    if (!sys_rst_ni) begin
      exp_valid_q <= 1'b0;
      exp_err_q   <= 1'b0;
      exp_rdata_q <= '0;
      mtimecmp_m  <= '1;
      msip_m      <= 1'b0;
    end else begin
      exp_valid_q <= req_i;
      exp_err_q   <= req_i && addr_bad(addr_i);
      exp_rdata_q <= '0;
      if (req_i && !addr_bad(addr_i)) begin
        if (!we_i) begin
          exp_rdata_q <= read_model(addr_i);
        end else if (addr_i[ADDR_W-1:OFFSET_W] == REGION_CLINT) begin
          if (word_ofs(addr_i) == CLINT_MSIP_OFS) msip_m <= wdata_i[0];
          if (word_ofs(addr_i) == CLINT_MTIMECMP_OFS) mtimecmp_m <= wdata_i;
        end
      end
    end
  end

  // Edge count, then two cycles until mtime shows it
  always_ff @(posedge clk_i or negedge sys_rst_ni) begin
    if (!sys_rst_ni) begin
      rtc_s      <= 1'b0;
      rtc_cnt    <= '0;
      rtc_cnt_d1 <= '0;
      mtime_m    <= '0;
    end else begin
      rtc_s      <= rtc_i;
      rtc_cnt    <= rtc_cnt + DATA_W'(rtc_i & ~rtc_s);
      rtc_cnt_d1 <= rtc_cnt;
      mtime_m    <= rtc_cnt_d1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      powered_cycles <= 0;
    end else if (powered_cycles < DEBUG_HOLDOFF_CYCLES) begin
      powered_cycles <= powered_cycles + 1;
    end
  end

  assign exp_irq = (mtime_m >= mtimecmp_m);
  assign exp_dbg = (powered_cycles >= DEBUG_HOLDOFF_CYCLES) && dbg_en_i && dbg_req_i;

  // ----------------------------------------
  // Assertions
  // ----------------------------------------

  a_rvalid: assert property (@(posedge clk_i) disable iff (!sys_rst_ni)
    rvalid_i == exp_valid_q)
    else begin
      $error("** Error @%0t: rvalid_o = %b, expected %b", $time,
             $sampled(rvalid_i), $sampled(exp_valid_q));
      fail_cnt = fail_cnt + 1;
    end

  a_err: assert property (@(posedge clk_i) disable iff (!sys_rst_ni)
    rvalid_i |-> err_i == exp_err_q)
    else begin
      $error("** Error @%0t: err_o = %b, expected %b", $time,
             $sampled(err_i), $sampled(exp_err_q));
      fail_cnt = fail_cnt + 1;
    end

  a_rdata: assert property (@(posedge clk_i) disable iff (!sys_rst_ni)
    rvalid_i |-> rdata_i == exp_rdata_q)
    else begin
      $error("** Error @%0t: rdata_o = %h, expected %h", $time,
             $sampled(rdata_i), $sampled(exp_rdata_q));
      fail_cnt = fail_cnt + 1;
    end

  a_timer_irq: assert property (@(posedge clk_i) disable iff (!sys_rst_ni)
    timer_irq_i == exp_irq)
    else begin
      $error("** Error @%0t: timer_irq_o = %b, expected %b", $time,
             $sampled(timer_irq_i), $sampled(exp_irq));
      fail_cnt = fail_cnt + 1;
    end

  a_ipi: assert property (@(posedge clk_i) disable iff (!sys_rst_ni)
    ipi_i == msip_m)
    else begin
      $error("** Error @%0t: ipi_o = %b, expected %b", $time,
             $sampled(ipi_i), $sampled(msip_m));
      fail_cnt = fail_cnt + 1;
    end

  a_debug: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dbg_out_i == exp_dbg)
    else begin
      $error("** Error @%0t: debug_req_o = %b, expected %b", $time,
             $sampled(dbg_out_i), $sampled(exp_dbg));
      fail_cnt = fail_cnt + 1;
    end

  a_reset_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(sys_rst_ni) |-> !rvalid_i && !err_i && !ipi_i && !timer_irq_i)
    else begin
      $error("Outputs were not low when the system reset was released");
      fail_cnt = fail_cnt + 1;
    end

endmodule

bind soc_fabric_top soc_fabric_chk u_chk (
  .clk_i       ( clk_i          ),
  .rst_ni      ( rst_ni         ),
  .sys_rst_ni  ( sys_rst_n      ),
  .rtc_i       ( rtc_i          ),
  .req_i       ( req_i          ),
  .we_i        ( we_i           ),
  .addr_i      ( addr_i         ),
  .be_i        ( be_i           ),
  .wdata_i     ( wdata_i        ),
  .dbg_req_i   ( debug_req_i    ),
  .dbg_en_i    ( debug_enable_i ),
  .rvalid_i    ( rvalid_o       ),
  .rdata_i     ( rdata_o        ),
  .err_i       ( err_o          ),
  .timer_irq_i ( timer_irq_o    ),
  .ipi_i       ( ipi_o          ),
  .dbg_out_i   ( debug_req_o    )
);

/* dv/soc_fabric_tb.sv */
`timescale 1ns/1ps

module soc_fabric_tb import bus_pkg::*, soc_map_pkg::*; ();

  localparam int CLK_NS       = 8;
  localparam int RST_CYCLES   = 10;
  localparam int N_SRAM       = 16;
  localparam int BUS_CYCLES   = ROM_WORDS + 4 * N_SRAM + 30;
  localparam int DBG_CYCLES   = 20;
  localparam int TIMER_CYCLES = 160;
  localparam int NDM_CYCLES   = 20 + N_SRAM;
  localparam int MARGIN       = 200;
  localparam int WATCHDOG_NS  =
    (RST_CYCLES + BUS_CYCLES + DBG_CYCLES + TIMER_CYCLES + NDM_CYCLES + MARGIN) * CLK_NS;

  logic              clk;
  logic              rst_n;
  logic              rtc;
  logic              ndmreset;
  logic              req;
  logic              we;
  logic [ADDR_W-1:0] addr;
  logic [BE_W-1:0]   be;
  logic [DATA_W-1:0] wdata;
  logic              dbg_req;
  logic              dbg_en;
  logic              rvalid;
  logic [DATA_W-1:0] rdata;
  logic              err;
  logic              timer_irq;
  logic              ipi;
  logic              dbg_out;

  logic [31:0]        lfsr_q;
  logic [SRAM_AW-1:0] idx;
  logic [ADDR_W-1:0]  sram_addr [N_SRAM];

  localparam logic [ADDR_W-1:0] MSIP_ADDR     = {REGION_CLINT, CLINT_MSIP_OFS};
  localparam logic [ADDR_W-1:0] MTIMECMP_ADDR = {REGION_CLINT, CLINT_MTIMECMP_OFS};
  localparam logic [ADDR_W-1:0] MTIME_ADDR    = {REGION_CLINT, CLINT_MTIME_OFS};

  soc_fabric_top DUT (
    .clk_i          ( clk       ),
    .rst_ni         ( rst_n     ),
    .rtc_i          ( rtc       ),
    .ndmreset_i     ( ndmreset  ),
    .req_i          ( req       ),
    .we_i           ( we        ),
    .addr_i         ( addr      ),
    .be_i           ( be        ),
    .wdata_i        ( wdata     ),
    .debug_req_i    ( dbg_req   ),
    .debug_enable_i ( dbg_en    ),
    .rvalid_o       ( rvalid    ),
    .rdata_o        ( rdata     ),
    .err_o          ( err       ),
    .timer_irq_o    ( timer_irq ),
    .ipi_o          ( ipi       ),
    .debug_req_o    ( dbg_out   )
  );

  always #(CLK_NS / 2) clk = ~clk;

  // Slow tick with a rising edge every ten cycles
  always begin
    repeat (5) @(negedge clk);
    rtc = ~rtc;
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v = {v[62:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic drive_request(input logic w, input logic [ADDR_W-1:0] a,
                               input logic [BE_W-1:0] b, input logic [DATA_W-1:0] d);
    req   = 1'b1;
    we    = w;
    addr  = a;
    be    = b;
    wdata = d;
    @(negedge clk);
  endtask

  task automatic hold_idle(input int n);
    req = 1'b0;
    we  = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  // ----------------------------------------
  // Failure and timeout
  // ----------------------------------------

  always @(posedge clk) begin
    if (DUT.u_chk.fail_cnt != 0) begin
      $display("SIMULATION FAILED");
      $fatal(1, "Assertion failure reported by the bound checker");
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("SIMULATION FAILED");
    $fatal(1, "Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------

  initial begin
    clk      = 1'b0;
    rst_n    = 1'b0;
    rtc      = 1'b0;
    ndmreset = 1'b0;
    req      = 1'b0;
    we       = 1'b0;
    addr     = '0;
    be       = '0;
    wdata    = '0;
    dbg_req  = 1'b1;
    dbg_en   = 1'b1;
    lfsr_q   = 32'h7bbf_2b62;
    repeat (RST_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    hold_idle(4);

    // Boot ROM words back to back
    for (int k = 0; k < ROM_WORDS; k++) begin
      drive_request(1'b0, ROM_BASE_ADDR + ADDR_W'(k * BE_W), '0, '0);
    end
    hold_idle(1);

    // SRAM fill and partial writes with a read behind each and a final read back
    for (int i = 0; i < N_SRAM; i++) begin
      idx = SRAM_AW'(rand_bits(SRAM_AW));
      sram_addr[i] = {REGION_DRAM, OFFSET_W'({idx, {WORD_OFS_W{1'b0}}})};
      drive_request(1'b1, sram_addr[i], '1, rand_bits(DATA_W));
    end
    for (int i = 0; i < N_SRAM; i++) begin
      drive_request(1'b1, sram_addr[i], BE_W'(rand_bits(BE_W)), rand_bits(DATA_W));
      drive_request(1'b0, sram_addr[i], '0, '0);
    end
    for (int i = 0; i < N_SRAM; i++) begin
      drive_request(1'b0, sram_addr[i], '0, '0);
    end
    hold_idle(1);

    // Bad addresses where the DRAM write aliases a live word
    drive_request(1'b0, {REGION_GPIO, 24'h00_0010}, '0, '0);
    drive_request(1'b1, {REGION_GPIO, 24'h00_0000}, '1, '1);
    drive_request(1'b0, 32'h1000_0000, '0, '0);
    drive_request(1'b0, ROM_BASE_ADDR - ADDR_W'(BE_W), '0, '0);
    drive_request(1'b0, ROM_BASE_ADDR + ADDR_W'(ROM_BYTES), '0, '0);
    drive_request(1'b1, sram_addr[0] + ADDR_W'(SRAM_BYTES), '1, '1);
    drive_request(1'b0, {REGION_CLINT, 24'h00_0100}, '0, '0);
    drive_request(1'b0, sram_addr[0], '0, '0);
    hold_idle(1);

    // Debug enable and request wander after the hold-off
    for (int i = 0; i < DBG_CYCLES; i++) begin
      dbg_req = 1'(rand_bits(1));
      dbg_en  = 1'(rand_bits(1));
      @(negedge clk);
    end
    dbg_req = 1'b1;
    dbg_en  = 1'b1;

    // Compare value is crossed by mtime during the idle stretch
    drive_request(1'b1, MTIMECMP_ADDR, '1, 64'd20);
    drive_request(1'b0, MTIME_ADDR, '0, '0);
    drive_request(1'b0, MTIMECMP_ADDR, '0, '0);
    drive_request(1'b1, MSIP_ADDR, '1, 64'd1);
    drive_request(1'b0, MSIP_ADDR, '0, '0);
    drive_request(1'b1, MSIP_ADDR, '1, 64'd0);
    drive_request(1'b0, MSIP_ADDR, '0, '0);
    drive_request(1'b1, MSIP_ADDR, '1, 64'd1);
    hold_idle(TIMER_CYCLES);
    drive_request(1'b0, MTIME_ADDR, '0, '0);
    drive_request(1'b1, MTIMECMP_ADDR, '1, 64'd5);
    hold_idle(2);

    // Debug reset pulse
    ndmreset = 1'b1;
    repeat (3) @(negedge clk);
    ndmreset = 1'b0;
    hold_idle(4);
    drive_request(1'b0, MTIME_ADDR, '0, '0);
    drive_request(1'b0, MSIP_ADDR, '0, '0);
    drive_request(1'b0, MTIMECMP_ADDR, '0, '0);
    for (int i = 0; i < N_SRAM; i++) begin
      drive_request(1'b0, sram_addr[i], '0, '0);
    end
    hold_idle(4);

    if (DUT.u_chk.fail_cnt == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("SIMULATION FAILED");
      $fatal(1, "Checker reported %0d failures", DUT.u_chk.fail_cnt);
    end
  end

endmodule

/* run.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module soc_fabric_tb \
  -f src.f -o soc_fabric_sim > sim.log 2>&1 &&
  ./obj_dir/soc_fabric_sim +verilator+error+limit+1000 >> sim.log 2>&1
grep -q "SIMULATION PASSED" sim.log && echo "Run passed" || { echo "Run failed, see sim.log"; exit 1; }

/* src.f */
src/bus_pkg.sv
src/soc_map_pkg.sv
src/rst_sync.sv
src/debug_gate.sv
src/addr_decode.sv
src/boot_rom.sv
src/sram_mem.sv
src/clint_timer.sv
src/soc_fabric_top.sv
dv/soc_fabric_chk.sv
dv/soc_fabric_tb.sv

/* src/addr_decode.sv */
`timescale 1ns/1ps

module addr_decode import bus_pkg::*, soc_map_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] rom_rdata_i,
  input  logic [DATA_W-1:0] sram_rdata_i,
  input  logic [DATA_W-1:0] clint_rdata_i,
  output logic              rom_req_o,
  output logic              sram_req_o,
  output logic              clint_req_o,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o,
  output logic              err_o
);

  soc_addr_u a;
  region_e   region;
  logic      rom_hit;
  logic      clint_hit;
  logic      dram_hit;
  logic      in_range;

  region_e   region_q;
  logic      rvalid_q;
  logic      err_q;
  logic      rd_q;

  assign a = addr_i;

  // ----------------------------------------
  // Request side
  // ----------------------------------------

  assign rom_hit  = (a.raw >= ROM_BASE_ADDR) && (a.raw < ROM_BASE_ADDR + ROM_BYTES);
  assign dram_hit = a.f.offset < SRAM_BYTES;

  // Low bits select a byte and are ignored
  assign clint_hit =
    (a.f.offset[OFFSET_W-1:WORD_OFS_W] == CLINT_MSIP_OFS[OFFSET_W-1:WORD_OFS_W]) ||
    (a.f.offset[OFFSET_W-1:WORD_OFS_W] == CLINT_MTIMECMP_OFS[OFFSET_W-1:WORD_OFS_W]) ||
    (a.f.offset[OFFSET_W-1:WORD_OFS_W] == CLINT_MTIME_OFS[OFFSET_W-1:WORD_OFS_W]);

  always_comb begin
    case (a.f.region)
      REGION_ROM:   region = TGT_ROM;
      REGION_CLINT: region = TGT_CLINT;
      REGION_GPIO:  region = TGT_GPIO;
      REGION_DRAM:  region = TGT_DRAM;
      default:      region = TGT_NONE;
    endcase
  end

  // GPIO has no target behind it
  always_comb begin
    case (region)
      TGT_ROM:   in_range = rom_hit;
      TGT_CLINT: in_range = clint_hit;
      TGT_DRAM:  in_range = dram_hit;
      default:   in_range = 1'b0;
    endcase
  end

  assign rom_req_o   = req_i & in_range & (region == TGT_ROM);
  assign sram_req_o  = req_i & in_range & (region == TGT_DRAM);
  assign clint_req_o = req_i & in_range & (region == TGT_CLINT);

  // ----------------------------------------
  // Response side
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
      rd_q     <= 1'b0;
      region_q <= TGT_NONE;
    end else begin
      rvalid_q <= req_i;
      err_q    <= req_i & ~in_range;
      rd_q     <= req_i & ~we_i;
      region_q <= region;
    end
  end

  always_comb begin
    rdata_o = '0;
    if (rvalid_q && rd_q && !err_q) begin
      case (region_q)
        TGT_ROM:   rdata_o = rom_rdata_i;
        TGT_CLINT: rdata_o = clint_rdata_i;
        TGT_DRAM:  rdata_o = sram_rdata_i;
        default:   rdata_o = '0;
      endcase
    end
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = err_q;

endmodule

/* src/boot_rom.sv */
`timescale 1ns/1ps

module boot_rom import bus_pkg::*, soc_map_pkg::*; (
  input  logic              clk_i,
  input  logic              req_i,
  input  logic [ADDR_W-1:0] addr_i,
  output logic [DATA_W-1:0] rdata_o
);

  soc_addr_u         a;
  logic [ROM_AW-1:0] idx;

  assign a   = addr_i;
  assign idx = a.raw[WORD_OFS_W +: ROM_AW];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= boot_rom_image[idx];
    end
  end

endmodule

/* src/bus_pkg.sv */
package bus_pkg;

  // ----------------------------------------
  // Request bus geometry
  // ----------------------------------------

  // Byte address width
  localparam int unsigned ADDR_W = 32;

  // One beat carries a full word
  localparam int unsigned DATA_W = 64;

  localparam int unsigned BE_W = DATA_W / 8;

  // Low address bits that pick a byte inside a word
  localparam int unsigned WORD_OFS_W = $clog2(BE_W);

endpackage

/* src/clint_timer.sv */
`timescale 1ns/1ps

module clint_timer import bus_pkg::*, soc_map_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              rtc_i,
  input  logic              req_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic [DATA_W-1:0] rdata_o,
  output logic              timer_irq_o,
  output logic              ipi_o
);

  soc_addr_u         a;
  logic [2:0]        rtc_q;
  logic              tick;
  logic [DATA_W-1:0] mtime_q;
  logic [DATA_W-1:0] mtimecmp_q;
  logic              msip_q;
  logic              sel_msip;
  logic              sel_mtimecmp;

  assign a = addr_i;

  // Decoder has already checked the offset, only tell registers apart
  assign sel_msip =
    a.f.offset[OFFSET_W-1:WORD_OFS_W] == CLINT_MSIP_OFS[OFFSET_W-1:WORD_OFS_W];
  assign sel_mtimecmp =
    a.f.offset[OFFSET_W-1:WORD_OFS_W] == CLINT_MTIMECMP_OFS[OFFSET_W-1:WORD_OFS_W];

  // ----------------------------------------
  // RTC edge detect and mtime
  // ----------------------------------------

  // Two flops to sample, third for the edge
  assign tick = rtc_q[1] & ~rtc_q[2];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rtc_q   <= 3'b000;
      mtime_q <= '0;
    end else begin
      rtc_q   <= {rtc_q[1:0], rtc_i};
      mtime_q <= mtime_q + DATA_W'(tick);
    end
  end

  // ----------------------------------------
  // Registers
  // ----------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtimecmp_q <= '1;
      msip_q     <= 1'b0;
      rdata_o    <= '0;
    end else if (req_i) begin
      if (we_i) begin
        if (sel_msip) msip_q <= wdata_i[0];
        if (sel_mtimecmp) mtimecmp_q <= wdata_i;
      end else if (sel_msip) begin
        rdata_o <= {{(DATA_W-1){1'b0}}, msip_q};
      end else if (sel_mtimecmp) begin
        rdata_o <= mtimecmp_q;
      end else begin
        rdata_o <= mtime_q;
      end
    end
  end

  assign timer_irq_o = (mtime_q >= mtimecmp_q);
  assign ipi_o       = msip_q;

endmodule

/* src/debug_gate.sv */
`timescale 1ns/1ps

module debug_gate import soc_map_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_enable_i,
  output logic debug_req_o
);

  logic [HOLDOFF_W-1:0] cnt_q;
  logic                 holdoff;

  assign holdoff = (cnt_q != '0);

  // Only power-on reloads the window, a debug reset does not
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= HOLDOFF_W'(DEBUG_HOLDOFF_CYCLES);
    end else if (holdoff) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = ~holdoff & debug_enable_i & debug_req_i;

endmodule

/* src/rst_sync.sv */
`timescale 1ns/1ps

module rst_sync (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic sys_rst_no
);

  logic       rst_comb_n;
  logic [1:0] sync_q;

  // Power-on and debug reset merged
  assign rst_comb_n = rst_ni & ~ndmreset_i;

  // Assert at once, release after two edges
  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign sys_rst_no = sync_q[1];

endmodule

/* src/soc_fabric_top.sv */
`timescale 1ns/1ps

module soc_fabric_top import bus_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              rtc_i,
  input  logic              ndmreset_i,
  input  logic              req_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [BE_W-1:0]   be_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  logic              debug_req_i,
  input  logic              debug_enable_i,
  output logic              rvalid_o,
  output logic [DATA_W-1:0] rdata_o,
  output logic              err_o,
  output logic              timer_irq_o,
  output logic              ipi_o,
  output logic              debug_req_o
);

  logic              sys_rst_n;
  logic              rom_req;
  logic              sram_req;
  logic              clint_req;
  logic [DATA_W-1:0] rom_rdata;
  logic [DATA_W-1:0] sram_rdata;
  logic [DATA_W-1:0] clint_rdata;

  // ----------------------------------------
  // Reset and debug
  // ----------------------------------------

  rst_sync i_rst_sync (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .ndmreset_i ( ndmreset_i ),
    .sys_rst_no ( sys_rst_n  )
  );

  debug_gate i_debug_gate (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .debug_req_i    ( debug_req_i    ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_o    ( debug_req_o    )
  );

  // ----------------------------------------
  // Fabric and targets
  // ----------------------------------------

  addr_decode i_addr_decode (
    .clk_i         ( clk_i       ),
    .rst_ni        ( sys_rst_n   ),
    .req_i         ( req_i       ),
    .we_i          ( we_i        ),
    .addr_i        ( addr_i      ),
    .rom_rdata_i   ( rom_rdata   ),
    .sram_rdata_i  ( sram_rdata  ),
    .clint_rdata_i ( clint_rdata ),
    .rom_req_o     ( rom_req     ),
    .sram_req_o    ( sram_req    ),
    .clint_req_o   ( clint_req   ),
    .rvalid_o      ( rvalid_o    ),
    .rdata_o       ( rdata_o     ),
    .err_o         ( err_o       )
  );

  boot_rom i_boot_rom (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .addr_i  ( addr_i    ),
    .rdata_o ( rom_rdata )
  );

  // Power-on reset only, contents outlive a debug reset
  sram_mem i_sram_mem (
    .clk_i   ( clk_i      ),
    .rst_ni  ( rst_ni     ),
    .req_i   ( sram_req   ),
    .we_i    ( we_i       ),
    .addr_i  ( addr_i     ),
    .be_i    ( be_i       ),
    .wdata_i ( wdata_i    ),
    .rdata_o ( sram_rdata )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i       ),
    .rst_ni      ( sys_rst_n   ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( clint_req   ),
    .we_i        ( we_i        ),
    .addr_i      ( addr_i      ),
    .wdata_i     ( wdata_i     ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

endmodule

/* src/soc_map_pkg.sv */
package soc_map_pkg;

  // ----------------------------------------
  // Address map
  // ----------------------------------------

  localparam int unsigned REGION_W = 8;
  localparam int unsigned OFFSET_W = bus_pkg::ADDR_W - REGION_W;

  // Target selected by the decoder
  typedef enum logic [2:0] {
    TGT_ROM,
    TGT_CLINT,
    TGT_GPIO,
    TGT_DRAM,
    TGT_NONE
  } region_e;

  // Top byte of the address
  localparam logic [REGION_W-1:0] REGION_ROM   = 8'h00;
  localparam logic [REGION_W-1:0] REGION_CLINT = 8'h02;
  localparam logic [REGION_W-1:0] REGION_GPIO  = 8'h40;
  localparam logic [REGION_W-1:0] REGION_DRAM  = 8'h80;

  localparam logic [OFFSET_W-1:0] ROM_BASE_OFS = 24'h01_0000;
  localparam int unsigned ROM_WORDS  = 8;
  localparam int unsigned ROM_AW     = $clog2(ROM_WORDS);
  localparam int unsigned ROM_BYTES  = ROM_WORDS * bus_pkg::BE_W;
  localparam logic [bus_pkg::ADDR_W-1:0] ROM_BASE_ADDR = {REGION_ROM, ROM_BASE_OFS};

  localparam int unsigned SRAM_WORDS = 1024;
  localparam int unsigned SRAM_AW    = $clog2(SRAM_WORDS);
  localparam int unsigned SRAM_BYTES = SRAM_WORDS * bus_pkg::BE_W;

  // CLINT register offsets, all word aligned
  localparam logic [OFFSET_W-1:0] CLINT_MSIP_OFS     = 24'h00_0000;
  localparam logic [OFFSET_W-1:0] CLINT_MTIMECMP_OFS = 24'h00_4000;
  localparam logic [OFFSET_W-1:0] CLINT_MTIME_OFS    = 24'h00_bff8;

  // Debug requests are held off while boot code runs
  localparam int unsigned DEBUG_HOLDOFF_CYCLES = 64;
  localparam int unsigned HOLDOFF_W = $clog2(DEBUG_HOLDOFF_CYCLES + 1);

  // Boot image, two instructions per word
  localparam logic [bus_pkg::DATA_W-1:0] boot_rom_image [ROM_WORDS] = '{
    64'h0202_8593_0000_0297,
    64'hf140_2573_0105_9593,
    64'h0005_8067_0201_0113,
    64'h1050_0073_0000_0013,
    64'hffdf_f06f_0000_0013,
    64'h0000_0000_0000_0000,
    64'hdead_beef_cafe_f00d,
    64'h8000_0000_0001_0000
  };

  // One address word, read raw or split into region and offset
  typedef struct packed {
    logic [REGION_W-1:0] region;
    logic [OFFSET_W-1:0] offset;
  } soc_addr_fields_t;

  typedef union packed {
    logic [bus_pkg::ADDR_W-1:0] raw;
    soc_addr_fields_t           f;
  } soc_addr_u;

endpackage

/* src/sram_mem.sv */
`timescale 1ns/1ps

module sram_mem import bus_pkg::*, soc_map_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  logic              we_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  logic [BE_W-1:0]   be_i,
  input  logic [DATA_W-1:0] wdata_i,
  output logic [DATA_W-1:0] rdata_o
);

  logic [DATA_W-1:0]  mem [SRAM_WORDS];
  soc_addr_u          a;
  logic [SRAM_AW-1:0] idx;

  assign a   = addr_i;
  assign idx = a.raw[WORD_OFS_W +: SRAM_AW];

  // Byte lanes written independently
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int i = 0; i < BE_W; i++) begin
        if (be_i[i]) begin
          mem[idx][i*8 +: 8] <= wdata_i[i*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i && !we_i) begin
      rdata_o <= mem[idx];
    end
  end

endmodule
